/* ddr_io_pads.f */
src/mem_pkg.sv
src/afi_pkg.sv
src/addr_cmd_pads.sv
src/dq_dqs_group.sv
src/io_config_chain.sv
src/ddr_io_pads.sv
verification/tb_ddr_io_pads.sv

/* src/addr_cmd_pads.sv */
`timescale 1ns/1ps

module addr_cmd_pads import afi_pkg::*, mem_pkg::*; #(
	parameter int REGISTER_C2P = 1
) (
	input logic pll_afi_clk,
	input logic arst_n,
	input afi_addr_t phy_ddio_address,
	input afi_bank_t phy_ddio_bank,
	input afi_ctrl_t phy_ddio_cs_n,
	input afi_ctrl_t phy_ddio_cke,
	input afi_ctrl_t phy_ddio_odt,
	input afi_ctrl_t phy_ddio_ras_n,
	input afi_ctrl_t phy_ddio_cas_n,
	input afi_ctrl_t phy_ddio_we_n,
	input logic enable_mem_clk,
	output mem_addr_t phy_mem_address,
	output mem_bank_t phy_mem_bank,
	output logic [MEM_CS_W-1:0] phy_mem_cs_n,
	output logic phy_mem_cke,
	output logic phy_mem_odt,
	output logic phy_mem_ras_n,
	output logic phy_mem_cas_n,
	output logic phy_mem_we_n,
	output logic phy_mem_ck,
	output logic phy_mem_ck_n
);

	afi_addr_t addr_c, addr_q;
	afi_bank_t bank_c, bank_q;
	afi_ctrl_t cs_n_c, cke_c, odt_c, ras_n_c, cas_n_c, we_n_c;
	afi_ctrl_t cs_n_q, cke_q, odt_q, ras_n_q, cas_n_q, we_n_q;
	logic slot;
	logic ck_en_q;

	if (REGISTER_C2P != 0) begin : g_c2p
		always_ff @(posedge pll_afi_clk) begin
			addr_c <= phy_ddio_address;
			bank_c <= phy_ddio_bank;
		end

		// Commands leave this stage inactive so the output register sees a NOP
		always_ff @(posedge pll_afi_clk or negedge arst_n) begin
			if (!arst_n) begin
				cs_n_c <= '1;
				cke_c <= '0;
				odt_c <= '0;
				ras_n_c <= '1;
				cas_n_c <= '1;
				we_n_c <= '1;
			end else begin
				cs_n_c <= phy_ddio_cs_n;
				cke_c <= phy_ddio_cke;
				odt_c <= phy_ddio_odt;
				ras_n_c <= phy_ddio_ras_n;
				cas_n_c <= phy_ddio_cas_n;
				we_n_c <= phy_ddio_we_n;
			end
		end
	end else begin : g_no_c2p
		always_comb begin
			addr_c = phy_ddio_address;
			bank_c = phy_ddio_bank;
			cs_n_c = phy_ddio_cs_n;
			cke_c = phy_ddio_cke;
			odt_c = phy_ddio_odt;
			ras_n_c = phy_ddio_ras_n;
			cas_n_c = phy_ddio_cas_n;
			we_n_c = phy_ddio_we_n;
		end
	end

	always_ff @(posedge pll_afi_clk) begin
		addr_q <= addr_c;
		bank_q <= bank_c;
	end

	always_ff @(posedge pll_afi_clk or negedge arst_n) begin
		if (!arst_n) begin
			cs_n_q <= '1;
			cke_q <= '0;
			odt_q <= '0;
			ras_n_q <= '1;
			cas_n_q <= '1;
			we_n_q <= '1;
		end else begin
			cs_n_q <= cs_n_c;
			cke_q <= cke_c;
			odt_q <= odt_c;
			ras_n_q <= ras_n_c;
			cas_n_q <= cas_n_c;
			we_n_q <= we_n_c;
		end
	end

	// DDIO output: high half of the clock carries t0, low half carries t1
	assign slot = ~pll_afi_clk;
	assign phy_mem_address = addr_slot(addr_q, slot);
	assign phy_mem_bank = bank_slot(bank_q, slot);
	assign phy_mem_cs_n = ctrl_slot(cs_n_q, slot);
	assign phy_mem_cke = ctrl_slot(cke_q, slot);
	assign phy_mem_odt = ctrl_slot(odt_q, slot);
	assign phy_mem_ras_n = ctrl_slot(ras_n_q, slot);
	assign phy_mem_cas_n = ctrl_slot(cas_n_q, slot);
	assign phy_mem_we_n = ctrl_slot(we_n_q, slot);

	// Enable changes only while the clock is low, so the gated clock never glitches
	always_ff @(negedge pll_afi_clk or negedge arst_n) begin
		if (!arst_n) begin
			ck_en_q <= 1'b0;
		end else begin
			ck_en_q <= enable_mem_clk;
		end
	end

	assign phy_mem_ck = pll_afi_clk & ck_en_q;
	assign phy_mem_ck_n = ~phy_mem_ck;

	// A slot that selects the device must also have it clocked
	a_cs_with_cke: assert property (@(posedge pll_afi_clk) disable iff (!arst_n)
		(~cs_n_q & ~cke_q) == '0)
		else $error("cs_n asserted while cke is low");

endmodule

/* src/afi_pkg.sv */
package afi_pkg;

	import mem_pkg::*;

	// Full rate AFI carries two time slots in every clock
	localparam int AFI_RATE_SLOTS = 2;

	// Slot t1 sits above slot t0 in every multi-slot AFI bus
	typedef logic [AFI_RATE_SLOTS*MEM_ADDR_W-1:0] afi_addr_t;
	typedef logic [AFI_RATE_SLOTS*MEM_BANK_W-1:0] afi_bank_t;
	typedef logic [AFI_RATE_SLOTS-1:0] afi_ctrl_t;

	// Pick the address of one slot, 0 for t0 and 1 for t1
	function automatic mem_addr_t addr_slot(afi_addr_t addr, logic slot);
		return addr[slot*MEM_ADDR_W +: MEM_ADDR_W];
	endfunction

	function automatic mem_bank_t bank_slot(afi_bank_t bank, logic slot);
		return bank[slot*MEM_BANK_W +: MEM_BANK_W];
	endfunction

	// Single command bit of one slot
	function automatic logic ctrl_slot(afi_ctrl_t ctrl, logic slot);
		return ctrl[slot];
	endfunction

endpackage

/* src/ddr_io_pads.sv */
`timescale 1ns/1ps

module ddr_io_pads import afi_pkg::*, mem_pkg::*; #(
	parameter int MEM_DQ_WIDTH = 16,
	parameter int MEM_DQS_WIDTH = 2,
	parameter int REGISTER_C2P = 1
) (
	input logic pll_afi_clk,
	input logic arst_n,

	input afi_addr_t phy_ddio_address,
	input afi_bank_t phy_ddio_bank,
	input afi_ctrl_t phy_ddio_cs_n,
	input afi_ctrl_t phy_ddio_cke,
	input afi_ctrl_t phy_ddio_odt,
	input afi_ctrl_t phy_ddio_ras_n,
	input afi_ctrl_t phy_ddio_cas_n,
	input afi_ctrl_t phy_ddio_we_n,

	input logic [2*MEM_DQ_WIDTH-1:0] phy_ddio_dq,
	input logic [2*MEM_DQS_WIDTH-1:0] phy_ddio_wrdata_mask,
	input logic [2*MEM_DQS_WIDTH-1:0] phy_ddio_wrdata_en,
	input logic [2*MEM_DQS_WIDTH-1:0] phy_ddio_dqs_en,
	input logic [2*MEM_DQS_WIDTH-1:0] dqs_enable_ctrl,
	input logic enable_mem_clk,

	input logic scc_data,
	input logic [MEM_DQS_WIDTH-1:0] scc_dqs_ena,
	input logic scc_upd,

	output mem_addr_t phy_mem_address,
	output mem_bank_t phy_mem_bank,
	output logic [MEM_CS_W-1:0] phy_mem_cs_n,
	output logic phy_mem_cke,
	output logic phy_mem_odt,
	output logic phy_mem_ras_n,
	output logic phy_mem_cas_n,
	output logic phy_mem_we_n,
	output logic phy_mem_ck,
	output logic phy_mem_ck_n,
	output logic [MEM_DQS_WIDTH-1:0] phy_mem_dm,

	inout wire [MEM_DQ_WIDTH-1:0] phy_mem_dq,
	inout wire [MEM_DQS_WIDTH-1:0] mem_dqs,

	output logic [2*MEM_DQ_WIDTH-1:0] ddio_phy_dq
);

	localparam int GW = MEM_DQ_WIDTH / MEM_DQS_WIDTH;

	// Active read latency of each group, loaded through the chain
	rd_lat_t grp_lat [MEM_DQS_WIDTH];

	addr_cmd_pads #(
		.REGISTER_C2P(REGISTER_C2P)
	) u_addr_cmd (
		.pll_afi_clk(pll_afi_clk),
		.arst_n(arst_n),
		.phy_ddio_address(phy_ddio_address),
		.phy_ddio_bank(phy_ddio_bank),
		.phy_ddio_cs_n(phy_ddio_cs_n),
		.phy_ddio_cke(phy_ddio_cke),
		.phy_ddio_odt(phy_ddio_odt),
		.phy_ddio_ras_n(phy_ddio_ras_n),
		.phy_ddio_cas_n(phy_ddio_cas_n),
		.phy_ddio_we_n(phy_ddio_we_n),
		.enable_mem_clk(enable_mem_clk),
		.phy_mem_address(phy_mem_address),
		.phy_mem_bank(phy_mem_bank),
		.phy_mem_cs_n(phy_mem_cs_n),
		.phy_mem_cke(phy_mem_cke),
		.phy_mem_odt(phy_mem_odt),
		.phy_mem_ras_n(phy_mem_ras_n),
		.phy_mem_cas_n(phy_mem_cas_n),
		.phy_mem_we_n(phy_mem_we_n),
		.phy_mem_ck(phy_mem_ck),
		.phy_mem_ck_n(phy_mem_ck_n)
	);

	io_config_chain #(
		.MEM_DQS_WIDTH(MEM_DQS_WIDTH)
	) u_cfg_chain (
		.pll_afi_clk(pll_afi_clk),
		.arst_n(arst_n),
		.scc_data(scc_data),
		.scc_dqs_ena(scc_dqs_ena),
		.scc_upd(scc_upd),
		.rd_lat(grp_lat)
	);

	// Core buses are slot major, so group g of t1 sits MEM_DQS_WIDTH slices above t0
	for (genvar g = 0; g < MEM_DQS_WIDTH; g++) begin : g_grp
		dq_dqs_group #(
			.MEM_DQ_WIDTH(MEM_DQ_WIDTH),
			.MEM_DQS_WIDTH(MEM_DQS_WIDTH),
			.REGISTER_C2P(REGISTER_C2P)
		) u_grp (
			.pll_afi_clk(pll_afi_clk),
			.arst_n(arst_n),
			.wr_dq({phy_ddio_dq[(MEM_DQS_WIDTH+g)*GW +: GW], phy_ddio_dq[g*GW +: GW]}),
			.wr_mask({phy_ddio_wrdata_mask[MEM_DQS_WIDTH+g], phy_ddio_wrdata_mask[g]}),
			.wr_en({phy_ddio_wrdata_en[MEM_DQS_WIDTH+g], phy_ddio_wrdata_en[g]}),
			.dqs_en({phy_ddio_dqs_en[MEM_DQS_WIDTH+g], phy_ddio_dqs_en[g]}),
			.rd_en({dqs_enable_ctrl[MEM_DQS_WIDTH+g], dqs_enable_ctrl[g]}),
			.rd_lat(grp_lat[g]),
			.dm(phy_mem_dm[g]),
			.rd_dq(ddio_phy_dq[g*2*GW +: 2*GW]),
			.dq(phy_mem_dq[g*GW +: GW]),
			.dqs(mem_dqs[g])
		);
	end

endmodule

/* src/dq_dqs_group.sv */
`timescale 1ns/1ps

module dq_dqs_group import mem_pkg::*; #(
	parameter int MEM_DQ_WIDTH = 16,
	parameter int MEM_DQS_WIDTH = 2,
	parameter int REGISTER_C2P = 1,
	localparam int GW = MEM_DQ_WIDTH / MEM_DQS_WIDTH
) (
	input logic pll_afi_clk,
	input logic arst_n,
	input logic [2*GW-1:0] wr_dq,
	input logic [1:0] wr_mask,
	input logic [1:0] wr_en,
	input logic [1:0] dqs_en,
	input logic [1:0] rd_en,
	input rd_lat_t rd_lat,
	output logic dm,
	output logic [2*GW-1:0] rd_dq,
	inout wire [GW-1:0] dq,
	inout wire dqs
);

	// Depth of the read delay line, one tap per latency value
	localparam int RD_DEPTH = 4;

	logic [2*GW-1:0] wr_dq_c, wr_dq_q;
	logic [1:0] wr_mask_c, wr_mask_q;
	logic [1:0] wr_en_c, wr_en_q;
	logic [1:0] dqs_en_c, dqs_en_q;
	logic slot;
	logic [GW-1:0] cap_rise, cap_fall;
	logic [2*GW-1:0] rd_line [RD_DEPTH];

	if (REGISTER_C2P != 0) begin : g_c2p
		always_ff @(posedge pll_afi_clk) begin
			wr_dq_c <= wr_dq;
			wr_mask_c <= wr_mask;
		end

		always_ff @(posedge pll_afi_clk or negedge arst_n) begin
			if (!arst_n) begin
				wr_en_c <= '0;
				dqs_en_c <= '0;
			end else begin
				wr_en_c <= wr_en;
				dqs_en_c <= dqs_en;
			end
		end
	end else begin : g_no_c2p
		always_comb begin
			wr_dq_c = wr_dq;
			wr_mask_c = wr_mask;
			wr_en_c = wr_en;
			dqs_en_c = dqs_en;
		end
	end

	// Output register of the write DDIO
	always_ff @(posedge pll_afi_clk) begin
		wr_dq_q <= wr_dq_c;
		wr_mask_q <= wr_mask_c;
	end

	always_ff @(posedge pll_afi_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_en_q <= '0;
			dqs_en_q <= '0;
		end else begin
			wr_en_q <= wr_en_c;
			dqs_en_q <= dqs_en_c;
		end
	end

	// Slot 0 while the clock is high, slot 1 while it is low
	assign slot = ~pll_afi_clk;

	assign dq = wr_en_q[slot] ? wr_dq_q[slot*GW +: GW] : {GW{1'bz}};
	assign dm = wr_en_q[slot] & wr_mask_q[slot];

	// The strobe is the AFI clock itself, centred on the edges of the data
	assign dqs = dqs_en_q[slot] ? pll_afi_clk : 1'bz;

	// Read capture on both edges of the same cycle
	always_ff @(posedge pll_afi_clk) begin
		cap_rise <= dq;
	end

	always_ff @(negedge pll_afi_clk) begin
		cap_fall <= dq;
	end

	// At the next rising edge the pair is realigned into the first stage.
	// The enable still holds the value it had during the capture cycle,
	// and a half without enable keeps what it had
	always_ff @(posedge pll_afi_clk) begin
		if (rd_en[0]) begin
			rd_line[0][GW-1:0] <= cap_rise;
		end
		if (rd_en[1]) begin
			rd_line[0][2*GW-1:GW] <= cap_fall;
		end
		for (int i = 1; i < RD_DEPTH; i++) begin
			rd_line[i] <= rd_line[i-1];
		end
	end

	// Each tap adds one whole cycle of delay
	assign rd_dq = rd_line[rd_lat];

	// Write data may only go out in a slot that also carries the strobe
	a_dq_needs_dqs: assert property (@(posedge pll_afi_clk) disable iff (!arst_n)
		(wr_en_q & ~dqs_en_q) == 2'b00)
		else $error("dq driven in a slot without dqs");

endmodule

/* src/io_config_chain.sv */
`timescale 1ns/1ps

module io_config_chain import mem_pkg::*; #(
	parameter int MEM_DQS_WIDTH = 2
) (
	input logic pll_afi_clk,
	input logic arst_n,
	input logic scc_data,
	input logic [MEM_DQS_WIDTH-1:0] scc_dqs_ena,
	input logic scc_upd,
	output rd_lat_t rd_lat [MEM_DQS_WIDTH]
);

	cfg_state_t state, state_nxt;
	rd_lat_t shadow [MEM_DQS_WIDTH];

	// An update is taken from idle or shift, and always lasts one cycle
	always_comb begin
		case (state)
			CFG_UPDATE: begin
				state_nxt = (|scc_dqs_ena) ? CFG_SHIFT : CFG_IDLE;
			end
			default: begin
				if (scc_upd) begin
					state_nxt = CFG_UPDATE;
				end else if (|scc_dqs_ena) begin
					state_nxt = CFG_SHIFT;
				end else begin
					state_nxt = CFG_IDLE;
				end
			end
		endcase
	end

	always_ff @(posedge pll_afi_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= CFG_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Serial data enters at the top bit, so the first bit lands in the LSB
	always_ff @(posedge pll_afi_clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int g = 0; g < MEM_DQS_WIDTH; g++) begin
				shadow[g] <= '0;
				rd_lat[g] <= '0;
			end
		end else begin
			for (int g = 0; g < MEM_DQS_WIDTH; g++) begin
				if (scc_dqs_ena[g]) begin
					shadow[g] <= {scc_data, shadow[g][1]};
				end
				if (state == CFG_UPDATE) begin
					rd_lat[g] <= shadow[g];
				end
			end
		end
	end

	// The sequencer must finish shifting before it asks for an update
	a_upd_not_during_shift: assert property (@(posedge pll_afi_clk) disable iff (!arst_n)
		!(scc_upd && (|scc_dqs_ena)))
		else $error("scc_upd in the same cycle as a shift strobe");

endmodule

/* src/mem_pkg.sv */
package mem_pkg;

	// Widths on the memory side of the pads
	localparam int MEM_ADDR_W = 13;
	localparam int MEM_BANK_W = 3;
	localparam int MEM_CS_W = 1;

	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [MEM_BANK_W-1:0] mem_bank_t;

	// Extra whole cycles of read capture delay, 0 to 3
	typedef logic [1:0] rd_lat_t;

	// States of the serial configuration chain
	typedef enum logic [1:0] {
		CFG_IDLE,
		CFG_SHIFT,
		CFG_UPDATE
	} cfg_state_t;

endpackage

/* verification/tb_ddr_io_pads.sv */
`timescale 1ns/1ps

module tb_ddr_io_pads import afi_pkg::*, mem_pkg::*;;

	localparam int DQ_W = 16;
	localparam int DQS_W = 2;
	localparam int C2P = 1;
	localparam int GW = DQ_W / DQS_W;
	localparam int WAIT_LIMIT = 40;

	logic pll_afi_clk;
	logic arst_n;
	afi_addr_t phy_ddio_address;
	afi_bank_t phy_ddio_bank;
	afi_ctrl_t phy_ddio_cs_n, phy_ddio_cke, phy_ddio_odt;
	afi_ctrl_t phy_ddio_ras_n, phy_ddio_cas_n, phy_ddio_we_n;
	logic [2*DQ_W-1:0] phy_ddio_dq;
	logic [2*DQS_W-1:0] phy_ddio_wrdata_mask, phy_ddio_wrdata_en, phy_ddio_dqs_en;
	logic [2*DQS_W-1:0] dqs_enable_ctrl;
	logic enable_mem_clk;
	logic scc_data;
	logic [DQS_W-1:0] scc_dqs_ena;
	logic scc_upd;
	mem_addr_t phy_mem_address;
	mem_bank_t phy_mem_bank;
	logic [MEM_CS_W-1:0] phy_mem_cs_n;
	logic phy_mem_cke, phy_mem_odt, phy_mem_ras_n, phy_mem_cas_n, phy_mem_we_n;
	logic phy_mem_ck, phy_mem_ck_n;
	logic [DQS_W-1:0] phy_mem_dm;
	wire [DQ_W-1:0] phy_mem_dq;
	wire [DQS_W-1:0] mem_dqs;
	logic [2*DQ_W-1:0] ddio_phy_dq;

	// Memory side read driver, one half cycle per data beat
	logic pad_oe;
	logic [DQ_W-1:0] pad_val, pad_rise_nx, pad_fall_nx;
	logic [2*DQS_W-1:0] pad_en_nx;

	// Expected values, each tagged with its cycle and clock phase
	int unsigned cyc;
	int unsigned exp_cyc[$];
	bit exp_low[$];
	string exp_name[$];
	int exp_grp[$];
	logic [31:0] exp_val[$];
	logic [2*GW-1:0] held [DQS_W];
	rd_lat_t lat_model [DQS_W];
	rd_lat_t shadow_model [DQS_W];
	int checks = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_err_start = 0;

	ddr_io_pads #(
		.MEM_DQ_WIDTH(DQ_W),
		.MEM_DQS_WIDTH(DQS_W),
		.REGISTER_C2P(C2P)
	) dut0 (.*);

	assign phy_mem_dq = pad_oe ? pad_val : {DQ_W{1'bz}};

	initial begin
		pll_afi_clk = 1'b0;
		forever begin
			#10 pll_afi_clk = ~pll_afi_clk;
		end
	end

	// Rise data is set up before the rising edge and fall data before the falling one
	always @(posedge pll_afi_clk or negedge pll_afi_clk) begin
		if (pll_afi_clk) begin
			pad_val <= pad_fall_nx;
			dqs_enable_ctrl <= pad_en_nx;
		end else begin
			pad_val <= pad_rise_nx;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s at %0t: got %h, expected %h", name, $time, got, exp);
		end
	endtask

	function automatic logic [31:0] observe(input string name, input int g);
		logic [31:0] v;
		v = '0;
		case (name)
			"phy_mem_address": v[MEM_ADDR_W-1:0] = phy_mem_address;
			"phy_mem_bank": v[MEM_BANK_W-1:0] = phy_mem_bank;
			"phy_mem_cs_n": v[MEM_CS_W-1:0] = phy_mem_cs_n;
			"phy_mem_cke": v[0] = phy_mem_cke;
			"phy_mem_odt": v[0] = phy_mem_odt;
			"phy_mem_ras_n": v[0] = phy_mem_ras_n;
			"phy_mem_cas_n": v[0] = phy_mem_cas_n;
			"phy_mem_we_n": v[0] = phy_mem_we_n;
			"phy_mem_ck": v[0] = phy_mem_ck;
			"phy_mem_ck_n": v[0] = phy_mem_ck_n;
			"phy_mem_dm": v[0] = phy_mem_dm[g];
			"phy_mem_dq": v[GW-1:0] = phy_mem_dq[g*GW +: GW];
			"mem_dqs": v[0] = mem_dqs[g];
			"ddio_phy_dq": v[2*GW-1:0] = ddio_phy_dq[g*2*GW +: 2*GW];
			default: v = 'x;
		endcase
		return v;
	endfunction

	// Reference model of the pin and capture rules
	function automatic logic [31:0] write_dq_ref(input logic [GW-1:0] data, input logic en);
		logic [31:0] v;
		v = '0;
		v[GW-1:0] = en ? data : {GW{1'bz}};
		return v;
	endfunction

	function automatic logic [31:0] strobe_ref(input logic en, input bit low);
		logic [31:0] v;
		v = '0;
		v[0] = en ? !low : 1'bz;
		return v;
	endfunction

	function automatic logic [2*GW-1:0] read_ref(input logic [2*GW-1:0] old,
		input logic [GW-1:0] rise, input logic [GW-1:0] fall, input logic [1:0] en);
		return {en[1] ? fall : old[2*GW-1:GW], en[0] ? rise : old[GW-1:0]};
	endfunction

	task automatic expect_at(input int unsigned at, input bit low, input string name,
		input int g, input logic [31:0] val);
		exp_cyc.push_back(at);
		exp_low.push_back(low);
		exp_name.push_back(name);
		exp_grp.push_back(g);
		exp_val.push_back(val);
	endtask

	task automatic compare_due(input bit low);
		string label;
		for (int i = exp_cyc.size() - 1; i >= 0; i--) begin
			if (exp_cyc[i] < cyc || (exp_cyc[i] == cyc && exp_low[i] == low)) begin
				label = exp_grp[i] < 0 ? exp_name[i] : $sformatf("%s[%0d]", exp_name[i], exp_grp[i]);
				if (exp_cyc[i] < cyc) begin
					errors++;
					$display("Value of %s for cycle %0d was never sampled", label, exp_cyc[i]);
				end else begin
					check_value(label, observe(exp_name[i], exp_grp[i]), exp_val[i]);
				end
				exp_cyc.delete(i);
				exp_low.delete(i);
				exp_name.delete(i);
				exp_grp.delete(i);
				exp_val.delete(i);
			end
		end
	endtask

	// Samples in the middle of each half period, well away from both edges
	initial begin
		cyc = 0;
		forever begin
			@(posedge pll_afi_clk);
			#5;
			cyc++;
			compare_due(1'b0);
			@(negedge pll_afi_clk);
			#5;
			compare_due(1'b1);
		end
	end

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_cyc.size() != 0 && n < WAIT_LIMIT) begin
			@(posedge pll_afi_clk);
			n++;
		end
		if (exp_cyc.size() != 0) begin
			errors++;
			$display("Timeout with %0d expected values still pending", exp_cyc.size());
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_err_start) begin
			$display("Test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: %0d errors", tests_run, name, errors - test_err_start);
		end
		test_err_start = errors;
	endtask

	task automatic check_reset_pins();
		check_value("phy_mem_cs_n", phy_mem_cs_n, {MEM_CS_W{1'b1}});
		check_value("phy_mem_cke", phy_mem_cke, 0);
		check_value("phy_mem_odt", phy_mem_odt, 0);
		check_value("phy_mem_dm", phy_mem_dm, 0);
		check_value("phy_mem_ck", phy_mem_ck, 0);
		check_value("phy_mem_ck_n", phy_mem_ck_n, 1);
		check_value("phy_mem_dq", phy_mem_dq, {DQ_W{1'bz}});
		check_value("mem_dqs", mem_dqs, {DQS_W{1'bz}});
	endtask

	// Word layout is address, bank, cs_n, cke, odt, ras_n, cas_n, we_n from the top
	task automatic run_addr_cmd(input int n);
		logic [21:0] cmd [2];
		for (int k = 0; k < n; k++) begin
			@(posedge pll_afi_clk);
			for (int s = 0; s < 2; s++) begin
				cmd[s] = $urandom;
				cmd[s][5] = cmd[s][5] | !cmd[s][4];
				expect_at(cyc + 2 + C2P, s, "phy_mem_address", -1, cmd[s][21:9]);
				expect_at(cyc + 2 + C2P, s, "phy_mem_bank", -1, cmd[s][8:6]);
				expect_at(cyc + 2 + C2P, s, "phy_mem_cs_n", -1, cmd[s][5]);
				expect_at(cyc + 2 + C2P, s, "phy_mem_cke", -1, cmd[s][4]);
				expect_at(cyc + 2 + C2P, s, "phy_mem_odt", -1, cmd[s][3]);
				expect_at(cyc + 2 + C2P, s, "phy_mem_ras_n", -1, cmd[s][2]);
				expect_at(cyc + 2 + C2P, s, "phy_mem_cas_n", -1, cmd[s][1]);
				expect_at(cyc + 2 + C2P, s, "phy_mem_we_n", -1, cmd[s][0]);
			end
			phy_ddio_address <= {cmd[1][21:9], cmd[0][21:9]};
			phy_ddio_bank <= {cmd[1][8:6], cmd[0][8:6]};
			phy_ddio_cs_n <= {cmd[1][5], cmd[0][5]};
			phy_ddio_cke <= {cmd[1][4], cmd[0][4]};
			phy_ddio_odt <= {cmd[1][3], cmd[0][3]};
			phy_ddio_ras_n <= {cmd[1][2], cmd[0][2]};
			phy_ddio_cas_n <= {cmd[1][1], cmd[0][1]};
			phy_ddio_we_n <= {cmd[1][0], cmd[0][0]};
		end
		@(posedge pll_afi_clk);
		phy_ddio_cs_n <= '1;
		phy_ddio_cke <= '1;
	endtask

	// The low half of the memory clock is low whatever the enable
	task automatic run_clock_gating(input int n);
		logic en;
		for (int k = 0; k < n; k++) begin
			@(posedge pll_afi_clk);
			en = $urandom;
			enable_mem_clk <= en;
			expect_at(cyc + 2, 1'b0, "phy_mem_ck", -1, en);
			expect_at(cyc + 2, 1'b0, "phy_mem_ck_n", -1, !en);
			expect_at(cyc + 2, 1'b1, "phy_mem_ck", -1, 0);
			expect_at(cyc + 2, 1'b1, "phy_mem_ck_n", -1, 1);
		end
		@(posedge pll_afi_clk);
		enable_mem_clk <= 1'b1;
	endtask

	task automatic run_writes(input int n);
		logic [2*DQ_W-1:0] data;
		logic [2*DQS_W-1:0] wen, sen, mask;
		int idx;
		for (int k = 0; k < n; k++) begin
			@(posedge pll_afi_clk);
			data = $urandom;
			wen = $urandom;
			sen = wen | 4'($urandom);
			mask = $urandom;
			phy_ddio_dq <= data;
			phy_ddio_wrdata_en <= wen;
			phy_ddio_dqs_en <= sen;
			phy_ddio_wrdata_mask <= mask;
			for (int g = 0; g < DQS_W; g++) begin
				for (int s = 0; s < 2; s++) begin
					idx = s * DQS_W + g;
					expect_at(cyc + 2 + C2P, s, "phy_mem_dq", g,
						write_dq_ref(data[idx*GW +: GW], wen[idx]));
					expect_at(cyc + 2 + C2P, s, "phy_mem_dm", g, wen[idx] & mask[idx]);
					expect_at(cyc + 2 + C2P, s, "mem_dqs", g, strobe_ref(sen[idx], s));
				end
			end
		end
		@(posedge pll_afi_clk);
		phy_ddio_wrdata_en <= '0;
		phy_ddio_dqs_en <= '0;
	endtask

	// Mode 0 disables capture, 1 picks random enables and 2 enables every half
	task automatic read_cycle(input int mode, input bit check);
		logic [DQ_W-1:0] rise, fall;
		logic [2*DQS_W-1:0] en;
		@(posedge pll_afi_clk);
		rise = $urandom;
		fall = $urandom;
		en = (mode == 2) ? '1 : (mode == 1) ? 4'($urandom) : '0;
		pad_rise_nx <= rise;
		pad_fall_nx <= fall;
		pad_en_nx <= en;
		for (int g = 0; g < DQS_W; g++) begin
			held[g] = read_ref(held[g], rise[g*GW +: GW], fall[g*GW +: GW],
				{en[DQS_W+g], en[g]});
			if (check) begin
				expect_at(cyc + 3 + lat_model[g], 1'b0, "ddio_phy_dq", g, held[g]);
			end
		end
	endtask

	// Bits go out LSB first while the group's shift strobe is high
	task automatic shift_lat(input int g, input rd_lat_t val);
		for (int b = 0; b < 2; b++) begin
			read_cycle(1, 1'b1);
			scc_dqs_ena <= DQS_W'(1) << g;
			scc_data <= val[b];
		end
		shadow_model[g] = val;
	endtask

	initial begin
		void'($urandom(32'h38bc_93ac));
		arst_n = 1'b0;
		phy_ddio_address = '0;
		phy_ddio_bank = '0;
		phy_ddio_cs_n = '1;
		phy_ddio_cke = '0;
		phy_ddio_odt = '0;
		phy_ddio_ras_n = '1;
		phy_ddio_cas_n = '1;
		phy_ddio_we_n = '1;
		phy_ddio_dq = '0;
		phy_ddio_wrdata_mask = '0;
		phy_ddio_wrdata_en = '0;
		phy_ddio_dqs_en = '0;
		dqs_enable_ctrl = '0;
		enable_mem_clk = 1'b0;
		scc_data = 1'b0;
		scc_dqs_ena = '0;
		scc_upd = 1'b0;
		pad_oe = 1'b0;
		pad_rise_nx = '0;
		pad_fall_nx = '0;
		pad_en_nx = '0;
		for (int g = 0; g < DQS_W; g++) begin
			lat_model[g] = '0;
		end

		for (int k = 0; k < 3; k++) begin
			@(posedge pll_afi_clk);
			#5;
			check_reset_pins();
			@(negedge pll_afi_clk);
			#5;
			check_reset_pins();
		end
		@(posedge pll_afi_clk);
		arst_n <= 1'b1;
		end_test("reset state");

		run_addr_cmd(24);
		wait_drain();
		end_test("address and command");

		run_clock_gating(24);
		wait_drain();
		end_test("memory clock gating");

		run_writes(32);
		wait_drain();
		end_test("write data, mask and strobe");

		@(posedge pll_afi_clk);
		pad_oe <= 1'b1;
		read_cycle(2, 1'b1);
		for (int k = 0; k < 24; k++) begin
			read_cycle(1, 1'b1);
		end
		wait_drain();
		end_test("read capture at latency 0");

		shift_lat(1, 2'd2);
		shift_lat(0, 2'd3);
		read_cycle(1, 1'b1);
		scc_dqs_ena <= '0;
		for (int k = 0; k < 4; k++) begin
			read_cycle(1, 1'b1);
		end
		read_cycle(0, 1'b0);
		scc_upd <= 1'b1;
		read_cycle(0, 1'b0);
		scc_upd <= 1'b0;
		for (int g = 0; g < DQS_W; g++) begin
			lat_model[g] = shadow_model[g];
		end
		for (int k = 0; k < 4; k++) begin
			read_cycle(0, 1'b0);
		end
		for (int k = 0; k < 20; k++) begin
			read_cycle(1, 1'b1);
		end
		wait_drain();
		end_test("configuration chain latency");

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule
